/* src/ex_pkg.sv */
// execute stage shared definitions: data width, opcodes and stage payloads
`default_nettype none

package ex_pkg;

  localparam int xlen = 64;

  typedef logic [4:0] reg_addr_t;

  typedef enum logic [3:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_slt   = 4'd3,
    alu_sltu  = 4'd4,
    alu_xor   = 4'd5,
    alu_srl   = 4'd6,
    alu_sra   = 4'd7,
    alu_or    = 4'd8,
    alu_and   = 4'd9,
    alu_pass2 = 4'd10
  } alu_op_e;

  typedef enum logic [3:0] {
    br_none = 4'd0,
    br_beq  = 4'd1,
    br_bne  = 4'd2,
    br_blt  = 4'd3,
    br_bge  = 4'd4,
    br_bltu = 4'd5,
    br_bgeu = 4'd6,
    br_jal  = 4'd7,
    br_jalr = 4'd8
  } br_op_e;

  // decode to execute payload
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic            use_rs1;
    logic            use_rs2;
    reg_addr_t       rs1_addr;
    reg_addr_t       rs2_addr;
    logic            is_word;
    alu_op_e         alu_op;
    br_op_e          br_op;
    logic [xlen-1:0] imm;
    logic            rd_wr_ena;
    reg_addr_t       rd_addr;
  } id_ex_t;

  // bypass source presented by MEM or WB
  typedef struct packed {
    logic            wr_ena;
    logic            is_load;
    reg_addr_t       rd_addr;
    logic [xlen-1:0] data;
  } fwd_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] result;
    logic [xlen-1:0] store_data;
    logic            rd_wr_ena;
    reg_addr_t       rd_addr;
  } ex_mem_t;

  typedef struct packed {
    logic [xlen-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* src/ex_forward.sv */
// operand bypass network: MEM over WB over register file, with load-use detection
`default_nettype none

module ex_forward (
  input  ex_pkg::reg_addr_t       rs1_addr,
  input  ex_pkg::reg_addr_t       rs2_addr,
  input  logic                    use_rs1,
  input  logic                    use_rs2,
  input  logic [ex_pkg::xlen-1:0] rs1_data,
  input  logic [ex_pkg::xlen-1:0] rs2_data,
  input  ex_pkg::fwd_t            mem_fwd,
  input  ex_pkg::fwd_t            wb_fwd,
  output logic [ex_pkg::xlen-1:0] rs1_value,
  output logic [ex_pkg::xlen-1:0] rs2_value,
  output logic                    hazard
);
  import ex_pkg::*;

  // msb flags a load still in MEM, low bits carry the chosen value
  function automatic logic [xlen:0] pick(input reg_addr_t addr, input logic used,
                                         input logic [xlen-1:0] rf_data,
                                         input fwd_t mem_src, input fwd_t wb_src);
    logic mem_hit;
    logic wb_hit;
    mem_hit = mem_src.wr_ena && (mem_src.rd_addr == addr);
    wb_hit  = wb_src.wr_ena && (wb_src.rd_addr == addr);
    if (addr == '0) begin
      // x0 is hardwired
      pick = '0;
    end else if (mem_hit) begin
      pick = {used && mem_src.is_load, mem_src.data};
    end else if (wb_hit) begin
      pick = {1'b0, wb_src.data};
    end else begin
      pick = {1'b0, rf_data};
    end
  endfunction

  logic [xlen:0] src1;
  logic [xlen:0] src2;

  assign src1 = pick(rs1_addr, use_rs1, rs1_data, mem_fwd, wb_fwd);
  assign src2 = pick(rs2_addr, use_rs2, rs2_data, mem_fwd, wb_fwd);

  assign rs1_value = src1[xlen-1:0];
  assign rs2_value = src2[xlen-1:0];
  assign hazard    = src1[xlen] | src2[xlen];

endmodule

`default_nettype wire

/* src/ex_alu.sv */
// 64-bit integer ALU with 32-bit word operation mode
`default_nettype none

module ex_alu (
  input  logic [ex_pkg::xlen-1:0] op1,
  input  logic [ex_pkg::xlen-1:0] op2,
  input  ex_pkg::alu_op_e         alu_op,
  input  logic                    is_word,
  output logic [ex_pkg::xlen-1:0] result
);
  import ex_pkg::*;

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] srl_src;
  logic [5:0]      shamt;
  logic [xlen-1:0] raw;

  // word mode sign-extends the low halves
  // unsigned order of sign-extended values matches 32-bit unsigned order
  assign a = is_word ? {{32{op1[31]}}, op1[31:0]} : op1;
  assign b = is_word ? {{32{op2[31]}}, op2[31:0]} : op2;

  // logical right shift must pull in zeros above bit 31 for srlw
  assign srl_src = is_word ? {32'b0, op1[31:0]} : op1;

  assign shamt = is_word ? {1'b0, op2[4:0]} : op2[5:0];

  always_comb begin
    unique case (alu_op)
      alu_add: begin
        raw = a + b;
      end
      alu_sub: begin
        raw = a - b;
      end
      alu_sll: begin
        raw = a << shamt;
      end
      alu_slt: begin
        raw = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      end
      alu_sltu: begin
        raw = {{(xlen-1){1'b0}}, a < b};
      end
      alu_xor: begin
        raw = a ^ b;
      end
      alu_srl: begin
        raw = srl_src >> shamt;
      end
      alu_sra: begin
        raw = $unsigned($signed(a) >>> shamt);
      end
      alu_or: begin
        raw = a | b;
      end
      alu_and: begin
        raw = a & b;
      end
      alu_pass2: begin
        raw = b;
      end
      default: begin
        raw = '0;
      end
    endcase
  end

  // word results come back sign-extended from bit 31
  assign result = is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

/* src/ex_branch.sv */
// branch condition evaluation and next-pc target for branches and jumps
`default_nettype none

module ex_branch (
  input  ex_pkg::br_op_e          br_op,
  input  logic [ex_pkg::xlen-1:0] rs1_value,
  input  logic [ex_pkg::xlen-1:0] rs2_value,
  input  logic [ex_pkg::xlen-1:0] pc,
  input  logic [ex_pkg::xlen-1:0] imm,
  output logic                    taken,
  output logic [ex_pkg::xlen-1:0] target
);
  import ex_pkg::*;

  logic            eq;
  logic            lt;
  logic            ltu;
  logic [xlen-1:0] jalr_sum;

  assign eq       = rs1_value == rs2_value;
  assign lt       = $signed(rs1_value) < $signed(rs2_value);
  assign ltu      = rs1_value < rs2_value;
  assign jalr_sum = rs1_value + imm;

  always_comb begin
    unique case (br_op)
      br_beq:  taken = eq;
      br_bne:  taken = !eq;
      br_blt:  taken = lt;
      br_bge:  taken = !lt;
      br_bltu: taken = ltu;
      br_bgeu: taken = !ltu;
      br_jal:  taken = 1'b1;
      br_jalr: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (br_op == br_jalr) begin
      // jalr drops bit 0 of the sum
      target = {jalr_sum[xlen-1:1], 1'b0};
    end else if (taken) begin
      target = pc + imm;
    end else begin
      // fall through
      target = pc + 64'd4;
    end
  end

endmodule

`default_nettype wire

/* src/ex_stage.sv */
// execute stage: stage register, operand bypass, ALU, branch resolve and redirect
`default_nettype none

module ex_stage (
  input  logic                    clk,
  input  logic                    rst,
  // from decode
  input  logic                    id_to_ex_valid,
  input  ex_pkg::id_ex_t          id_to_ex,
  output logic                    ex_allowin,
  // to memory
  output logic                    ex_to_mem_valid,
  output ex_pkg::ex_mem_t         ex_to_mem,
  input  logic                    mem_allowin,
  // register file read
  output ex_pkg::reg_addr_t       rs1_addr,
  output ex_pkg::reg_addr_t       rs2_addr,
  input  logic [ex_pkg::xlen-1:0] rs1_data,
  input  logic [ex_pkg::xlen-1:0] rs2_data,
  // bypass from later stages
  input  ex_pkg::fwd_t            mem_fwd,
  input  ex_pkg::fwd_t            wb_fwd,
  // redirect to fetch
  output logic                    redirect_valid,
  output ex_pkg::redirect_t       redirect,
  input  logic                    redirect_ready
);
  import ex_pkg::*;

  logic            ex_valid;
  id_ex_t          ex_r;
  logic            redirect_done;
  logic            ready_go;
  logic            hazard;
  logic            is_branch;
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;
  logic [xlen-1:0] alu_op1;
  logic [xlen-1:0] alu_op2;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] br_target;

  assign is_branch = ex_r.br_op != br_none;

  // a branch may leave once fetch has taken its redirect, now or earlier
  assign ready_go   = !hazard && (!is_branch || redirect_done || redirect_ready);
  assign ex_allowin = !ex_valid || (ready_go && mem_allowin);
  assign ex_to_mem_valid = ex_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (id_to_ex_valid && ex_allowin) begin
      ex_r <= id_to_ex;
    end
  end

  // redirect accepted while the next stage is still blocked
  always_ff @(posedge clk) begin
    if (rst) begin
      redirect_done <= 1'b0;
    end else if (ex_allowin) begin
      redirect_done <= 1'b0;
    end else if (redirect_valid && redirect_ready) begin
      redirect_done <= 1'b1;
    end
  end

  assign rs1_addr = ex_r.rs1_addr;
  assign rs2_addr = ex_r.rs2_addr;

  ex_forward u_forward (
    .rs1_addr  (ex_r.rs1_addr),
    .rs2_addr  (ex_r.rs2_addr),
    .use_rs1   (ex_r.use_rs1),
    .use_rs2   (ex_r.use_rs2),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .mem_fwd   (mem_fwd),
    .wb_fwd    (wb_fwd),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .hazard    (hazard)
  );

  assign alu_op1 = ex_r.use_rs1 ? rs1_value : ex_r.op1;
  assign alu_op2 = ex_r.use_rs2 ? rs2_value : ex_r.op2;

  ex_alu u_alu (
    .op1     (alu_op1),
    .op2     (alu_op2),
    .alu_op  (ex_r.alu_op),
    .is_word (ex_r.is_word),
    .result  (alu_result)
  );

  // fetch needs only the target, taken or not
  ex_branch u_branch (
    .br_op     (ex_r.br_op),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .pc        (ex_r.pc),
    .imm       (ex_r.imm),
    .taken     (),
    .target    (br_target)
  );

  assign redirect_valid  = ex_valid && is_branch && !hazard && !redirect_done;
  assign redirect.target = br_target;

  assign ex_to_mem.pc         = ex_r.pc;
  assign ex_to_mem.result     = alu_result;
  assign ex_to_mem.store_data = rs2_value;
  assign ex_to_mem.rd_wr_ena  = ex_r.rd_wr_ena;
  assign ex_to_mem.rd_addr    = ex_r.rd_addr;

endmodule

`default_nettype wire

/* test/ex_stage_asserts.sv */
// handshake checks for the execute stage, attached to ex_stage by bind
`default_nettype none

module ex_stage_asserts (
  input logic            clk,
  input logic            rst,
  input logic            mem_allowin,
  input logic            ex_to_mem_valid,
  input ex_pkg::ex_mem_t ex_to_mem,
  input logic            ex_allowin,
  input logic            redirect_valid,
  input logic            hazard
);
  timeunit 1ns;
  timeprecision 100ps;

  // read by the testbench checker
  int err_count = 0;

  // a blocked output keeps both valid and payload
  assert property (@(posedge clk) disable iff (rst)
    ex_to_mem_valid && !mem_allowin |=> ex_to_mem_valid && $stable(ex_to_mem))
  else begin
    err_count++;
    $error("ex_to_mem changed while mem_allowin was low");
  end

  assert property (@(posedge clk) disable iff (rst) hazard |-> !ex_to_mem_valid)
  else begin
    err_count++;
    $error("ex_to_mem_valid high during a load-use hazard");
  end

  // stage is empty right after reset
  assert property (@(posedge clk) rst |=> !ex_to_mem_valid && !redirect_valid && ex_allowin)
  else begin
    err_count++;
    $error("stage outputs active in the cycle after reset");
  end

endmodule

bind ex_stage ex_stage_asserts u_ex_asserts (
  .clk             (clk),
  .rst             (rst),
  .mem_allowin     (mem_allowin),
  .ex_to_mem_valid (ex_to_mem_valid),
  .ex_to_mem       (ex_to_mem),
  .ex_allowin      (ex_allowin),
  .redirect_valid  (redirect_valid),
  .hazard          (hazard)
);

`default_nettype wire

/* test/ex_stage_tb.sv */
// testbench for the execute stage: stage models, random stimulus, reference and checker
`default_nettype none

module ex_stage_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ex_pkg::*;

  typedef struct packed {
    logic            is_branch;
    logic [xlen-1:0] target;
    ex_mem_t         out;
  } expect_t;

  logic            clk = 1'b0;
  logic            rst;
  logic            id_to_ex_valid;
  id_ex_t          id_to_ex;
  logic            ex_allowin;
  logic            ex_to_mem_valid;
  ex_mem_t         ex_to_mem;
  logic            mem_allowin = 1'b0;
  reg_addr_t       rs1_addr;
  reg_addr_t       rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  fwd_t            mem_fwd;
  fwd_t            wb_fwd;
  logic            redirect_valid;
  redirect_t       redirect;
  logic            redirect_ready = 1'b0;

  logic [xlen-1:0] regs [32];
  logic [31:0]     rng;
  logic [31:0]     hs_rng = 32'h3d8f;
  logic            ready_high = 1'b0;
  logic            redirect_seen = 1'b0;
  expect_t         pending [$];
  int              sent = 0;
  int              retired = 0;

  ex_stage DUT (.*);

  always #4 clk = ~clk;

  // register file answers in the same cycle
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic draw64(output logic [xlen-1:0] v);
    rng = xorshift(rng);
    v[63:32] = rng;
    rng = xorshift(rng);
    v[31:0] = rng;
  endtask

  // youngest producer wins, x0 is always zero
  function automatic logic [xlen-1:0] source_value(input reg_addr_t addr, input fwd_t m,
                                                   input fwd_t w);
    if (addr == 5'd0) return '0;
    if (m.wr_ena && m.rd_addr == addr) return m.data;
    if (w.wr_ena && w.rd_addr == addr) return w.data;
    return regs[addr];
  endfunction

  function automatic expect_t exp_ex(input id_ex_t p, input fwd_t m, input fwd_t w);
    expect_t         e;
    logic [xlen-1:0] v1;
    logic [xlen-1:0] v2;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] r;
    logic [31:0]     a32;
    logic [31:0]     b32;
    logic [31:0]     r32;
    logic            cond;
    v1 = source_value(p.rs1_addr, m, w);
    v2 = source_value(p.rs2_addr, m, w);
    a = p.use_rs1 ? v1 : p.op1;
    b = p.use_rs2 ? v2 : p.op2;
    a32 = a[31:0];
    b32 = b[31:0];
    if (p.is_word) begin
      case (p.alu_op)
        alu_add:   r32 = a32 + b32;
        alu_sub:   r32 = a32 - b32;
        alu_sll:   r32 = a32 << b32[4:0];
        alu_slt:   r32 = {31'd0, $signed(a32) < $signed(b32)};
        alu_sltu:  r32 = {31'd0, a32 < b32};
        alu_xor:   r32 = a32 ^ b32;
        alu_srl:   r32 = a32 >> b32[4:0];
        alu_sra:   r32 = $signed(a32) >>> b32[4:0];
        alu_or:    r32 = a32 | b32;
        alu_and:   r32 = a32 & b32;
        alu_pass2: r32 = b32;
        default:   r32 = '0;
      endcase
      r = {{32{r32[31]}}, r32};
    end else begin
      case (p.alu_op)
        alu_add:   r = a + b;
        alu_sub:   r = a - b;
        alu_sll:   r = a << b[5:0];
        alu_slt:   r = {63'd0, $signed(a) < $signed(b)};
        alu_sltu:  r = {63'd0, a < b};
        alu_xor:   r = a ^ b;
        alu_srl:   r = a >> b[5:0];
        alu_sra:   r = $signed(a) >>> b[5:0];
        alu_or:    r = a | b;
        alu_and:   r = a & b;
        alu_pass2: r = b;
        default:   r = '0;
      endcase
    end
    case (p.br_op)
      br_beq:  cond = v1 == v2;
      br_bne:  cond = v1 != v2;
      br_blt:  cond = $signed(v1) < $signed(v2);
      br_bge:  cond = $signed(v1) >= $signed(v2);
      br_bltu: cond = v1 < v2;
      br_bgeu: cond = v1 >= v2;
      default: cond = 1'b1;
    endcase
    e.is_branch = p.br_op != br_none;
    if (p.br_op == br_jalr) begin
      e.target = (v1 + p.imm) & ~64'd1;
    end else if (cond) begin
      e.target = p.pc + p.imm;
    end else begin
      e.target = p.pc + 64'd4;
    end
    e.out.pc = p.pc;
    e.out.result = r;
    e.out.store_data = v2;
    e.out.rd_wr_ena = p.rd_wr_ena;
    e.out.rd_addr = p.rd_addr;
    return e;
  endfunction

  task automatic make_random(output id_ex_t p, output fwd_t m, output fwd_t w);
    logic [xlen-1:0] x;
    draw64(x);
    p.pc = {x[63:2], 2'b00};
    draw64(p.op1);
    draw64(p.op2);
    draw64(p.imm);
    draw64(m.data);
    draw64(w.data);
    draw64(x);
    p.use_rs1 = x[0];
    p.use_rs2 = x[1];
    p.rs1_addr = x[6:2];
    p.rs2_addr = x[11:7];
    p.is_word = x[12];
    p.alu_op = alu_op_e'(x[19:16] % 4'd11);
    p.br_op = br_none;
    p.rd_wr_ena = x[20];
    p.rd_addr = x[25:21];
    m.wr_ena = x[26];
    m.is_load = 1'b0;
    m.rd_addr = x[31:27];
    w.wr_ena = x[32];
    w.is_load = 1'b0;
    w.rd_addr = x[37:33];
  endtask

  // offer one instruction, then hold its bypass values while it is in the stage
  task automatic issue(input id_ex_t p, input fwd_t m, input fwd_t w, input int stall);
    fwd_t held;
    int   n;
    id_to_ex_valid = 1'b1;
    id_to_ex = p;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 200) abort_run("timeout waiting for ex_allowin");
    end while (!ex_allowin);
    @(posedge clk);
    pending.push_back(exp_ex(p, m, w));
    sent++;
    #1;
    id_to_ex_valid = 1'b0;
    held = m;
    held.is_load = stall > 0;
    mem_fwd = held;
    wb_fwd = w;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk);
      assert (!ex_to_mem_valid && !redirect_valid)
      else abort_run("instruction left the stage during a load-use stall");
      @(posedge clk);
      #1;
    end
    mem_fwd = m;
  endtask

  // downstream and fetch handshakes
  always @(posedge clk) begin
    #1;
    hs_rng = xorshift(hs_rng);
    mem_allowin = hs_rng[1:0] != 2'b00;
    redirect_ready = ready_high || hs_rng[3:2] == 2'b00;
  end

  always @(negedge clk) begin : check_outputs
    expect_t e;
    if (!rst) begin
      assert (DUT.u_ex_asserts.err_count == 0)
      else abort_run("a handshake assertion on ex_stage failed");
      if (redirect_valid) begin
        assert (pending.size() > 0 && pending[0].is_branch)
        else abort_run("redirect offered without a branch in the stage");
        assert (!redirect_seen)
        else abort_run("redirect offered again after fetch had taken it");
        assert (redirect.target == pending[0].target)
        else abort_run($sformatf("[ERROR] redirect.target exp %h got %h",
                                 pending[0].target, redirect.target));
        if (redirect_ready) redirect_seen = 1'b1;
      end
      if (ex_to_mem_valid && mem_allowin) begin
        assert (pending.size() > 0) else abort_run("an instruction left that was never accepted");
        e = pending.pop_front();
        assert (!e.is_branch || redirect_seen)
        else abort_run("branch passed on before its redirect was taken");
        assert (ex_to_mem == e.out)
        else abort_run($sformatf("[ERROR] ex_to_mem exp %h got %h", e.out, ex_to_mem));
        redirect_seen = 1'b0;
        retired++;
      end
    end
  end

  initial begin
    id_ex_t p;
    fwd_t   m;
    fwd_t   w;
    int     n;
    rst = 1'b1;
    id_to_ex_valid = 1'b0;
    id_to_ex = '0;
    mem_fwd = '0;
    wb_fwd = '0;
    rng = 32'h3d8f;
    for (int i = 0; i < 32; i++) begin
      regs[i] = {8{3'b101, i[4:0]}} ^ 64'h0123_4567_89ab_cdef;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // every opcode, word and doubleword, immediate operands
    for (int op = 0; op < 11; op++) begin
      for (int k = 0; k < 6; k++) begin
        make_random(p, m, w);
        p.alu_op = alu_op_e'(op[3:0]);
        p.is_word = k[0];
        p.use_rs1 = 1'b0;
        p.use_rs2 = 1'b0;
        issue(p, m, w, 0);
      end
    end

    // MEM over WB over register file, then x0
    for (int k = 0; k < 4; k++) begin
      make_random(p, m, w);
      p.alu_op = alu_add;
      p.is_word = 1'b0;
      p.use_rs1 = 1'b1;
      p.use_rs2 = 1'b0;
      p.op2 = '0;
      p.rs1_addr = (k == 3) ? 5'd0 : 5'd9;
      m.wr_ena = k == 0 || k == 3;
      m.rd_addr = p.rs1_addr;
      w.wr_ena = k != 2;
      w.rd_addr = p.rs1_addr;
      issue(p, m, w, 0);
    end

    // load in MEM feeding rs1, then rs2
    for (int k = 0; k < 2; k++) begin
      make_random(p, m, w);
      p.use_rs1 = k == 0;
      p.use_rs2 = k == 1;
      p.rs1_addr = 5'd12;
      p.rs2_addr = 5'd13;
      m.wr_ena = 1'b1;
      m.rd_addr = (k == 0) ? 5'd12 : 5'd13;
      issue(p, m, w, 3);
    end

    // each branch op, fetch always ready and then ready at random
    for (int mode = 0; mode < 2; mode++) begin
      @(negedge clk);
      ready_high = mode == 0;
      @(posedge clk);
      #1;
      for (int b = 1; b < 9; b++) begin
        for (int k = 0; k < 2; k++) begin
          make_random(p, m, w);
          p.br_op = br_op_e'(b[3:0]);
          p.use_rs1 = 1'b1;
          p.use_rs2 = 1'b1;
          if (k == 1) p.rs2_addr = p.rs1_addr;
          issue(p, m, w, 0);
        end
      end
    end

    // mixed traffic under back-pressure
    for (int k = 0; k < 40; k++) begin
      make_random(p, m, w);
      rng = xorshift(rng);
      if (rng[2:0] == 3'd0) p.br_op = br_op_e'(4'd1 + {1'b0, rng[5:3]});
      issue(p, m, w, 0);
    end

    n = 0;
    while (pending.size() != 0 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (pending.size() != 0 || retired != sent) begin
      abort_run("instructions were lost or never left the stage");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* ex_stage.f */
src/ex_pkg.sv
src/ex_forward.sv
src/ex_alu.sv
src/ex_branch.sv
src/ex_stage.sv
test/ex_stage_asserts.sv
test/ex_stage_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build ex_stage_tb with Verilator and run it"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --timescale 1ns/100ps \
		--top-module ex_stage_tb -f ex_stage.f --Mdir obj_dir -o ex_stage_sim
	./obj_dir/ex_stage_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended without passing"; exit 1; fi
	@echo "simulation ok"

clean:
	rm -rf obj_dir $(LOG)
